//--- Makefile
# Verilator build for the FFT stage and its testbench

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_fft_stage
RTL_TOP   ?= fft_stage_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
PASS_MSG  ?= sim passed
VFLAGS    ?= --timing --assert
SIM_BIN   := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# the log decides the result, the exit status of the run is not used
sim: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation finished cleanly"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src.f
+incdir+src
src/fft_stage_pkg.sv
src/cpair_if.sv
src/sample_unpack.sv
src/twiddle_mult.sv
src/butterfly_add.sv
src/output_pack.sv
src/fft_stage_top.sv
tests/tb_fft_stage.sv

//--- src/butterfly_add.sv
`timescale 1ns/1ps
`include "fft_stage_config.svh"

module butterfly_add (
        input  logic CLK,
        input  logic i_reset,
        cpair_if.snk i_twid,
        cpair_if.src o_bfly
);

        import fft_stage_pkg::*;

        // upper bits must all match the sign of an 11 bit value
        function automatic logic fits_tw(input prod_t v);
                fits_tw = (v[`FFT_PROD_BITS-1:`FFT_OUT_BITS-2]
                           == {(`FFT_PROD_BITS-`FFT_OUT_BITS+2){v[`FFT_OUT_BITS-2]}});
        endfunction

        prod_t t_re [`FFT_LANES];
        prod_t t_im [`FFT_LANES];

        always_comb begin
                for (int j = 0; j < `FFT_LANES; j++) begin
                        t_re[j] = i_twid.b_re[j] >>> `FFT_TW_FRAC;     // floor
                        t_im[j] = i_twid.b_im[j] >>> `FFT_TW_FRAC;
                end
        end

        always_ff @(posedge CLK) begin
                if (i_reset) begin
                        for (int j = 0; j < `FFT_LANES; j++) begin
                                o_bfly.a_re[j] <= '0;
                                o_bfly.a_im[j] <= '0;
                                o_bfly.b_re[j] <= '0;
                                o_bfly.b_im[j] <= '0;
                        end
                end else begin
                        for (int j = 0; j < `FFT_LANES; j++) begin
                                o_bfly.a_re[j] <= sum_t'(i_twid.a_re[j]) + sum_t'(t_re[j]);
                                o_bfly.a_im[j] <= sum_t'(i_twid.a_im[j]) + sum_t'(t_im[j]);
                                o_bfly.b_re[j] <= sum_t'(i_twid.a_re[j]) - sum_t'(t_re[j]);
                                o_bfly.b_im[j] <= sum_t'(i_twid.a_im[j]) - sum_t'(t_im[j]);
                        end
                end
        end

        // unit twiddles keep |t| near 724, so m +/- t still narrows to the output width
        for (genvar j = 0; j < `FFT_LANES; j++) begin : g_chk
                a_tw_fits: assert property (@(posedge CLK) disable iff (i_reset)
                        fits_tw(t_re[j]) && fits_tw(t_im[j]));
        end

endmodule

//--- src/cpair_if.sv
`timescale 1ns/1ps
`include "fft_stage_config.svh"

// two complex operands per butterfly lane, valid every cycle
interface cpair_if #(
        parameter int A_BITS = 10,
        parameter int B_BITS = 10
);

        logic signed [A_BITS-1:0] a_re [`FFT_LANES];
        logic signed [A_BITS-1:0] a_im [`FFT_LANES];
        logic signed [B_BITS-1:0] b_re [`FFT_LANES];
        logic signed [B_BITS-1:0] b_im [`FFT_LANES];

        modport src (
                output a_re, a_im,
                output b_re, b_im
        );

        modport snk (
                input a_re, a_im,
                input b_re, b_im
        );

endinterface

//--- src/fft_stage_config.svh
`ifndef FFT_STAGE_CONFIG_SVH
`define FFT_STAGE_CONFIG_SVH

// input samples
`define FFT_COMP_BITS   10      // one signed real or imag component
`define FFT_IN_BITS     20      // packed {re, im}

// twiddle, Q1.11 signed
`define FFT_TW_BITS     13
`define FFT_TW_FRAC     11
`define FFT_TW_ONE      2048    // 1.0
`define FFT_TW_COS45    1448    // 0.70710678 scaled, rounded

// datapath widths
`define FFT_PROD_BITS   24      // full complex product component
`define FFT_SUM_BITS    14      // m +/- t, exact
`define FFT_OUT_BITS    12      // per output component

// structure
`define FFT_LANES       4       // butterflies per group of eight
`define FFT_LATENCY     4       // clock edges from input sample to o_c

`endif

//--- src/fft_stage_pkg.sv
`include "fft_stage_config.svh"

package fft_stage_pkg;

        // one signed component of an input sample
        typedef logic signed [`FFT_COMP_BITS-1:0] comp_t;

        // packed input sample, real part in the upper half
        typedef logic [`FFT_IN_BITS-1:0] sample_in_t;

        // n * twiddle before the rescale
        typedef logic signed [`FFT_PROD_BITS-1:0] prod_t;

        // butterfly sum or difference
        typedef logic signed [`FFT_SUM_BITS-1:0] sum_t;

        // narrowed output component
        typedef logic signed [`FFT_OUT_BITS-1:0] res_t;

        // packed output sample {re, im}
        typedef logic [2*`FFT_OUT_BITS-1:0] sample_out_t;

endpackage

//--- src/fft_stage_top.sv
`timescale 1ns/1ps
`include "fft_stage_config.svh"

module fft_stage_top (
        input  logic                       CLK,
        input  logic                       i_reset,
        input  fft_stage_pkg::sample_in_t  i_b [2*`FFT_LANES],
        output fft_stage_pkg::sample_out_t o_c [2*`FFT_LANES]
);

        // m and n straight from the inputs
        cpair_if #(.A_BITS(`FFT_COMP_BITS), .B_BITS(`FFT_COMP_BITS)) unpack_bus ();

        // delayed m, full width t
        cpair_if #(.A_BITS(`FFT_COMP_BITS), .B_BITS(`FFT_PROD_BITS)) twid_bus ();

        // sum in a, difference in b
        cpair_if #(.A_BITS(`FFT_SUM_BITS), .B_BITS(`FFT_SUM_BITS)) bfly_bus ();

        sample_unpack u_unpack (
                .CLK     (CLK),
                .i_reset (i_reset),
                .i_b     (i_b),
                .o_ops   (unpack_bus.src)
        );

        twiddle_mult u_twiddle (
                .CLK     (CLK),
                .i_reset (i_reset),
                .i_ops   (unpack_bus.snk),
                .o_twid  (twid_bus.src)
        );

        butterfly_add u_bfly (
                .CLK     (CLK),
                .i_reset (i_reset),
                .i_twid  (twid_bus.snk),
                .o_bfly  (bfly_bus.src)
        );

        output_pack u_pack (
                .CLK     (CLK),
                .i_reset (i_reset),
                .i_bfly  (bfly_bus.snk),
                .o_c     (o_c)
        );

endmodule

//--- src/output_pack.sv
`timescale 1ns/1ps
`include "fft_stage_config.svh"

module output_pack (
        input  logic                       CLK,
        input  logic                       i_reset,
        cpair_if.snk                       i_bfly,
        output fft_stage_pkg::sample_out_t o_c [2*`FFT_LANES]
);

        import fft_stage_pkg::*;

        function automatic sample_out_t pack(input sum_t re, input sum_t im);
                pack = {res_t'(re), res_t'(im)};
        endfunction

        // dropped msbs are copies of the kept sign bit
        function automatic logic no_loss(input sum_t v);
                no_loss = (v[`FFT_SUM_BITS-1:`FFT_OUT_BITS-1]
                           == {(`FFT_SUM_BITS-`FFT_OUT_BITS+1){v[`FFT_OUT_BITS-1]}});
        endfunction

        always_ff @(posedge CLK) begin
                if (i_reset) begin
                        for (int j = 0; j < 2*`FFT_LANES; j++) begin
                                o_c[j] <= '0;
                        end
                end else begin
                        for (int j = 0; j < `FFT_LANES; j++) begin
                                o_c[j] <= pack(i_bfly.a_re[j], i_bfly.a_im[j]);        // m + t
                                o_c[j + `FFT_LANES] <= pack(i_bfly.b_re[j], i_bfly.b_im[j]);
                        end
                end
        end

        // holds only while inputs stay within the 10 bit range sampled three edges back
        for (genvar j = 0; j < `FFT_LANES; j++) begin : g_chk
                a_sum_fits: assert property (@(posedge CLK) disable iff (i_reset)
                        no_loss(i_bfly.a_re[j]) && no_loss(i_bfly.a_im[j]));
                a_diff_fits: assert property (@(posedge CLK) disable iff (i_reset)
                        no_loss(i_bfly.b_re[j]) && no_loss(i_bfly.b_im[j]));
        end

endmodule

//--- src/sample_unpack.sv
`timescale 1ns/1ps
`include "fft_stage_config.svh"

module sample_unpack (
        input  logic                     CLK,
        input  logic                     i_reset,
        input  fft_stage_pkg::sample_in_t i_b [2*`FFT_LANES],
        cpair_if.src                     o_ops
);

        import fft_stage_pkg::*;

        function automatic comp_t re_part(input sample_in_t s);
                re_part = comp_t'(s[`FFT_IN_BITS-1 -: `FFT_COMP_BITS]);
        endfunction

        function automatic comp_t im_part(input sample_in_t s);
                im_part = comp_t'(s[`FFT_COMP_BITS-1:0]);
        endfunction

        // m = b[j], n = b[j+4]
        always_ff @(posedge CLK) begin
                if (i_reset) begin
                        for (int j = 0; j < `FFT_LANES; j++) begin
                                o_ops.a_re[j] <= '0;
                                o_ops.a_im[j] <= '0;
                                o_ops.b_re[j] <= '0;
                                o_ops.b_im[j] <= '0;
                        end
                end else begin
                        for (int j = 0; j < `FFT_LANES; j++) begin
                                o_ops.a_re[j] <= re_part(i_b[j]);
                                o_ops.a_im[j] <= im_part(i_b[j]);
                                o_ops.b_re[j] <= re_part(i_b[j + `FFT_LANES]);
                                o_ops.b_im[j] <= im_part(i_b[j + `FFT_LANES]);
                        end
                end
        end

endmodule

//--- src/twiddle_mult.sv
`timescale 1ns/1ps
`include "fft_stage_config.svh"

module twiddle_mult (
        input  logic CLK,
        input  logic i_reset,
        cpair_if.snk i_ops,
        cpair_if.src o_twid
);

        import fft_stage_pkg::*;

        localparam logic signed [`FFT_TW_BITS-1:0] W_ONE = `FFT_TW_BITS'(`FFT_TW_ONE);
        localparam logic signed [`FFT_TW_BITS-1:0] W_C45 = `FFT_TW_BITS'(`FFT_TW_COS45);

        // W8^lane = c + j*d
        function automatic logic signed [`FFT_TW_BITS-1:0] twiddle(input int lane,
                                                                  input logic imag);
                logic signed [`FFT_TW_BITS-1:0] c;
                logic signed [`FFT_TW_BITS-1:0] d;
                case (lane)
                1: begin
                        c = W_C45;
                        d = -W_C45;
                end
                2: begin
                        c = '0;
                        d = -W_ONE;     // -j
                end
                3: begin
                        c = -W_C45;
                        d = -W_C45;
                end
                default: begin
                        c = W_ONE;      // lane 0, plain pass
                        d = '0;
                end
                endcase
                twiddle = imag ? d : c;
        endfunction

        prod_t t_re [`FFT_LANES];
        prod_t t_im [`FFT_LANES];

        always_comb begin
                for (int j = 0; j < `FFT_LANES; j++) begin
                        t_re[j] = prod_t'(i_ops.b_re[j]) * prod_t'(twiddle(j, 1'b0))
                                - prod_t'(i_ops.b_im[j]) * prod_t'(twiddle(j, 1'b1));
                        t_im[j] = prod_t'(i_ops.b_re[j]) * prod_t'(twiddle(j, 1'b1))
                                + prod_t'(i_ops.b_im[j]) * prod_t'(twiddle(j, 1'b0));
                end
        end

        always_ff @(posedge CLK) begin
                if (i_reset) begin
                        for (int j = 0; j < `FFT_LANES; j++) begin
                                o_twid.a_re[j] <= '0;
                                o_twid.a_im[j] <= '0;
                                o_twid.b_re[j] <= '0;
                                o_twid.b_im[j] <= '0;
                        end
                end else begin
                        for (int j = 0; j < `FFT_LANES; j++) begin
                                o_twid.a_re[j] <= i_ops.a_re[j];   // m rides along with t
                                o_twid.a_im[j] <= i_ops.a_im[j];
                                o_twid.b_re[j] <= t_re[j];
                                o_twid.b_im[j] <= t_im[j];
                        end
                end
        end

endmodule

//--- tests/tb_fft_stage.sv
`timescale 1ns/1ps
`include "fft_stage_config.svh"

module tb_fft_stage;

        import fft_stage_pkg::*;

        localparam int NSAMP = 2*`FFT_LANES;
        localparam int OUT_W = 2*`FFT_OUT_BITS;
        localparam int GRP_IN_W = NSAMP*`FFT_IN_BITS;
        localparam int GRP_OUT_W = NSAMP*OUT_W;
        localparam int RESET_CYCLES = 16;
        localparam int RANDOM_GROUPS = 500;
        localparam int DRAIN_LIMIT = 64;
        localparam logic [31:0] SEED = 32'h052afa0b;

        // W8^j = c + j*d in Q1.11
        localparam int TW_C [`FFT_LANES] = '{`FFT_TW_ONE, `FFT_TW_COS45, 0, -`FFT_TW_COS45};
        localparam int TW_D [`FFT_LANES] = '{0, -`FFT_TW_COS45, -`FFT_TW_ONE, -`FFT_TW_COS45};

        logic        CLK;
        logic        i_reset;
        sample_in_t  i_b [NSAMP];
        sample_out_t o_c [NSAMP];

        logic [31:0]          lfsr_state;
        int                   edge_cnt;
        logic                 rst_prev;         // reset value the DUT samples on the next edge
        int                   exp_due [$];      // edge after which o_c must hold the group
        logic [GRP_OUT_W-1:0] exp_val [$];
        int                   chk_due;
        logic [GRP_OUT_W-1:0] chk_want;

        fft_stage_top DUT (
                .CLK     (CLK),
                .i_reset (i_reset),
                .i_b     (i_b),
                .o_c     (o_c)
        );

        always #2 CLK = ~CLK;

        // x^32 + x^22 + x^2 + x + 1
        function automatic logic lfsr_bit();
                logic fb;
                fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
                lfsr_state = {lfsr_state[30:0], fb};
                return fb;
        endfunction

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        v = {v[30:0], lfsr_bit()};
                end
                return v;
        endfunction

        function automatic sample_in_t make_sample(input int re, input int im);
                return {comp_t'(re), comp_t'(im)};
        endfunction

        function automatic int comp_of(input sample_in_t s, input logic imag);
                comp_t v;
                v = imag ? s[`FFT_COMP_BITS-1:0] : s[`FFT_IN_BITS-1 -: `FFT_COMP_BITS];
                return int'(v);
        endfunction

        // expected o_c for one group: out[j] = m + n*W8^j, out[j+4] = m - n*W8^j
        function automatic logic [GRP_OUT_W-1:0] ref_group(input logic [GRP_IN_W-1:0] g);
                logic [GRP_OUT_W-1:0] r;
                sample_in_t m;
                sample_in_t n;
                int tr;
                int ti;
                r = '0;
                for (int j = 0; j < `FFT_LANES; j++) begin
                        m = g[j*`FFT_IN_BITS +: `FFT_IN_BITS];
                        n = g[(j+`FFT_LANES)*`FFT_IN_BITS +: `FFT_IN_BITS];
                        tr = (comp_of(n, 1'b0)*TW_C[j] - comp_of(n, 1'b1)*TW_D[j]) >>> `FFT_TW_FRAC;
                        ti = (comp_of(n, 1'b0)*TW_D[j] + comp_of(n, 1'b1)*TW_C[j]) >>> `FFT_TW_FRAC;
                        r[j*OUT_W +: OUT_W] = {res_t'(comp_of(m, 1'b0) + tr),
                                               res_t'(comp_of(m, 1'b1) + ti)};
                        r[(j+`FFT_LANES)*OUT_W +: OUT_W] = {res_t'(comp_of(m, 1'b0) - tr),
                                                            res_t'(comp_of(m, 1'b1) - ti)};
                end
                return r;
        endfunction

        function automatic logic [GRP_IN_W-1:0] impulse_group(input int lane, input sample_in_t s);
                logic [GRP_IN_W-1:0] g;
                g = '0;
                g[(lane+`FFT_LANES)*`FFT_IN_BITS +: `FFT_IN_BITS] = s;
                return g;
        endfunction

        function automatic logic [GRP_IN_W-1:0] fill_group(input sample_in_t m, input sample_in_t n);
                logic [GRP_IN_W-1:0] g;
                for (int j = 0; j < `FFT_LANES; j++) begin
                        g[j*`FFT_IN_BITS +: `FFT_IN_BITS] = m;
                        g[(j+`FFT_LANES)*`FFT_IN_BITS +: `FFT_IN_BITS] = n;
                end
                return g;
        endfunction

        function automatic logic [GRP_IN_W-1:0] random_group();
                logic [GRP_IN_W-1:0] g;
                for (int i = 0; i < NSAMP; i++) begin
                        g[i*`FFT_IN_BITS +: `FFT_IN_BITS] = rand_bits(`FFT_IN_BITS);
                end
                return g;
        endfunction

        task automatic stop_with_failure(input string why);
                $display("%s", why);
                $display("sim failed");
                $fatal(1);
        endtask

        task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
                if (got !== want) begin
                        $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, want);
                        stop_with_failure("output value check failed");
                end
        endtask

        task automatic push_expect(input int due, input logic [GRP_OUT_W-1:0] val);
                exp_due.push_back(due);
                exp_val.push_back(val);
        endtask

        // one rising edge: drive reset and a group, then record what o_c must show
        task automatic drive_group(input logic rst, input logic [GRP_IN_W-1:0] g);
                @(posedge CLK);
                edge_cnt++;
                i_reset <= rst;
                for (int i = 0; i < NSAMP; i++) begin
                        i_b[i] <= g[i*`FFT_IN_BITS +: `FFT_IN_BITS];
                end
                if (rst) begin
                        // groups still in the pipeline are wiped by the reset
                        while (exp_due.size() > 0 && exp_due[exp_due.size()-1] > edge_cnt) begin
                                void'(exp_due.pop_back());
                                void'(exp_val.pop_back());
                        end
                end
                if (rst_prev) push_expect(edge_cnt, '0);   // reset sampled on this edge
                if (!rst) begin
                        if (rst_prev) begin
                                for (int k = 1; k < `FFT_LATENCY; k++) begin
                                        push_expect(edge_cnt + k, '0);  // cleared stages drain
                                end
                        end
                        push_expect(edge_cnt + `FFT_LATENCY, ref_group(g));
                end
                rst_prev = rst;
        endtask

        task automatic hold_step();
                @(posedge CLK);
                edge_cnt++;
        endtask

        always @(negedge CLK) begin
                if (exp_due.size() > 0 && exp_due[0] < edge_cnt) begin
                        stop_with_failure($sformatf("expected group for edge %0d was never compared",
                                                    exp_due[0]));
                end
                while (exp_due.size() > 0 && exp_due[0] == edge_cnt) begin
                        chk_due = exp_due.pop_front();
                        chk_want = exp_val.pop_front();
                        for (int i = 0; i < NSAMP; i++) begin
                                check_eq(o_c[i], chk_want[i*OUT_W +: OUT_W],
                                         $sformatf("o_c[%0d] after edge %0d", i, chk_due));
                        end
                end
        end

        initial begin
                CLK = 1'b0;
                i_reset = 1'b1;
                for (int i = 0; i < NSAMP; i++) begin
                        i_b[i] = '0;
                end
                lfsr_state = SEED;
                edge_cnt = 0;
                rst_prev = 1'b1;

                repeat (RESET_CYCLES - 1) drive_group(1'b1, '0);

                // a single n per lane shows each twiddle on its own
                for (int j = 0; j < `FFT_LANES; j++) begin
                        drive_group(1'b0, impulse_group(j, make_sample(300, -200)));
                        drive_group(1'b0, impulse_group(j, make_sample(-512, 511)));
                        drive_group(1'b0, impulse_group(j, make_sample(511, -512)));
                        drive_group(1'b0, impulse_group(j, make_sample(1, 0)));
                end

                // full scale corners
                drive_group(1'b0, fill_group(make_sample(-512, -512), make_sample(-512, -512)));
                drive_group(1'b0, fill_group(make_sample(511, 511), make_sample(511, 511)));
                drive_group(1'b0, fill_group(make_sample(-512, -512), make_sample(511, -512)));
                drive_group(1'b0, fill_group(make_sample(511, -512), make_sample(-512, 511)));

                for (int i = 0; i < RANDOM_GROUPS; i++) begin
                        if (i == RANDOM_GROUPS/2) begin
                                repeat (3) drive_group(1'b1, random_group());
                        end
                        drive_group(1'b0, random_group());
                end

                for (int i = 0; i < DRAIN_LIMIT && exp_due.size() > 0; i++) begin
                        hold_step();
                end
                if (exp_due.size() > 0) begin
                        stop_with_failure("timeout while waiting for the last groups on o_c");
                end else begin
                        $display("sim passed");
                        $finish;
                end
        end

endmodule
